// ==== logic/scan_pkg.sv ====
// Scanner package with frame constants, frame categories and stream/status structs
`default_nettype none

package scan_pkg;

	// Octet position in a frame, 0 is the first destination MAC octet
	typedef logic [10:0] pos_t;

	// Frames reaching this position are dropped mid-stream
	localparam pos_t max_frame = 11'd1536;

	// Minimum idle cycles ahead of a start delimiter
	localparam logic [3:0] ifg_min = 4'd10;

	// Config memory layout
	// MAC at 0..5, IPv4 at cfg_ip_base..cfg_ip_base+3
	localparam int unsigned cfg_ip_base = 6;

	// Frame class, in rising priority
	typedef enum logic [1:0] {
		cat_other = 2'd0,
		cat_arp   = 2'd1,
		cat_icmp  = 2'd2,
		cat_udp   = 2'd3
	} category_e;

	// One beat of the octet stream
	typedef struct packed {
		logic [7:0] data;
		// High on octet 0 only
		logic       first;
	} octet_s;

	// End-of-frame summary
	typedef struct packed {
		category_e category;
		logic      pass_ethmac;
		logic      pass_ip;
		// Position of the last octet
		pos_t      frame_len;
	} scan_status_s;

endpackage

`default_nettype wire

// ==== logic/frame_fsm.sv ====
// Receive frame FSM with preamble, delimiter and gap checks, position count and output delay
`timescale 1ns/1ps
`default_nettype none

module frame_fsm
	import scan_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [7:0] eth_in,
	input  wire        eth_in_s,
	input  wire        enable_rx,
	output pos_t       pos,
	output logic       in_frame,
	output octet_s     data_d1,
	output octet_s     odata,
	output logic       odata_s,
	output logic       frame_end,
	output pos_t       frame_len
);

	// Enable comes from another domain
	logic [1:0] rx_en_q;
	// One-hot state
	logic st_idle, st_pre, st_data, st_drop;
	logic [3:0] ifg_count;
	logic ifg_inc, ifg_ok, drop_now;
	logic data_st_d1;

	// Gap counter stops at 12
	assign ifg_inc  = ~&ifg_count[3:2];
	assign ifg_ok   = ifg_count >= ifg_min;
	assign drop_now = pos >= max_frame;
	assign in_frame = st_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_en_q   <= 2'b00;
			st_idle   <= 1'b1;
			st_pre    <= 1'b0;
			st_data   <= 1'b0;
			st_drop   <= 1'b0;
			ifg_count <= 4'd12;
		end else begin
			rx_en_q <= {rx_en_q[0], enable_rx};
			// Gap only grows while nothing is being received
			if (st_idle | st_pre)
				ifg_count <= ifg_count + {3'd0, ifg_inc};
			else
				ifg_count <= 4'd0;
			// Enable is looked at once, on the first octet
			if (st_idle && eth_in_s) begin
				st_idle <= 1'b0;
				if (eth_in == 8'h55 && rx_en_q[1])
					st_pre <= 1'b1;
				else
					st_drop <= 1'b1;
			end
			if (st_pre) begin
				if (eth_in_s && eth_in == 8'hd5) begin
					st_pre <= 1'b0;
					// Delimiter too soon after the last frame
					if (ifg_ok)
						st_data <= 1'b1;
					else
						st_drop <= 1'b1;
				end else if (eth_in_s && eth_in != 8'h55) begin
					st_pre  <= 1'b0;
					st_drop <= 1'b1;
				end else if (!eth_in_s) begin
					st_pre  <= 1'b0;
					st_idle <= 1'b1;
				end
			end
			if (st_data) begin
				if (!eth_in_s) begin
					st_data <= 1'b0;
					st_idle <= 1'b1;
				end else if (drop_now) begin
					st_data <= 1'b0;
					st_drop <= 1'b1;
				end
			end
			// Rest of a bad frame is swallowed
			if (st_drop && !eth_in_s) begin
				st_drop <= 1'b0;
				st_idle <= 1'b1;
			end
		end
	end

	// Position, the delayed data state and the last octet position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos        <= '0;
			data_st_d1 <= 1'b0;
			odata_s    <= 1'b0;
			frame_len  <= '0;
		end else begin
			pos        <= st_data ? pos + 11'd1 : '0;
			data_st_d1 <= st_data;
			// Data state runs one cycle past the last octet, trim it
			odata_s    <= st_data & data_st_d1;
			if (st_data && eth_in_s)
				frame_len <= pos;
		end
	end

	// Two-stage octet pipeline, idle octets read as zero
	always_ff @(posedge clk) begin
		data_d1.data  <= eth_in_s ? eth_in : 8'h00;
		data_d1.first <= st_data & ~data_st_d1;
		odata         <= data_d1;
	end

	// Normal end only, a drop lands in st_drop instead
	assign frame_end = data_st_d1 & st_idle;

	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot({st_idle, st_pre, st_data, st_drop}))
		else $error("frame FSM state is not one-hot");

endmodule

`default_nettype wire

// ==== logic/ones_chksum.sv ====
// Byte-serial 16-bit one's-complement sum with an all-ones flag
`timescale 1ns/1ps
`default_nettype none

module ones_chksum (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       clear,
	input  wire       gate,
	input  wire [7:0] din,
	output logic      all_ones
);

	// Even octets go to the high lane
	logic        hi_lane;
	logic [15:0] sum;
	logic [15:0] addend;
	logic [16:0] raw;

	assign addend = hi_lane ? {din, 8'h00} : {8'h00, din};
	assign raw    = {1'b0, sum} + {1'b0, addend};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi_lane <= 1'b1;
			sum     <= 16'h0000;
		end else if (clear) begin
			hi_lane <= 1'b1;
			sum     <= 16'h0000;
		end else if (gate) begin
			hi_lane <= ~hi_lane;
			// End-around carry, cannot overflow a second time
			sum     <= raw[15:0] + {15'd0, raw[16]};
		end
	end

	assign all_ones = &sum;

endmodule

`default_nettype wire

// ==== logic/addr_match.sv ====
// Address matcher for destination MAC, IPv4 destination and ARP target against config memory
`timescale 1ns/1ps
`default_nettype none

module addr_match
	import scan_pkg::*;
#(
	parameter int cfg_aw = 4
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire pos_t         pos,
	input  wire octet_s       data_d1,
	output logic [cfg_aw-1:0] cfg_addr,
	input  wire  [7:0]        cfg_data,
	output logic              pass_ethmac,
	output logic              pass_dst_ip,
	output logic              pass_arp_ip
);

	logic win_eth, win_ip, win_arp;
	logic want_eth, want_ip, want_arp;
	logic cfg_hit;

	// Destination MAC, IPv4 destination, ARP target IP
	assign win_eth = pos < 11'd6;
	assign win_ip  = pos >= 11'd30 && pos < 11'd34;
	assign win_arp = pos >= 11'd38 && pos < 11'd42;

	// Both IP windows read the same four bytes
	always_comb begin
		if (win_ip)
			cfg_addr = cfg_aw'(pos - 11'd30 + 11'(cfg_ip_base));
		else if (win_arp)
			cfg_addr = cfg_aw'(pos - 11'd38 + 11'(cfg_ip_base));
		else
			cfg_addr = cfg_aw'(pos);
	end

	// Memory answer and the octet line up one cycle on
	assign cfg_hit = cfg_data == data_d1.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want_eth    <= 1'b0;
			want_ip     <= 1'b0;
			want_arp    <= 1'b0;
			pass_ethmac <= 1'b0;
			pass_dst_ip <= 1'b0;
			pass_arp_ip <= 1'b0;
		end else begin
			want_eth <= win_eth;
			want_ip  <= win_ip;
			want_arp <= win_arp;
			// Flags start high each frame and any mismatch clears them for good
			if (pos == '0) begin
				pass_ethmac <= 1'b1;
				pass_dst_ip <= 1'b1;
				pass_arp_ip <= 1'b1;
			end else begin
				if (want_eth && !cfg_hit)
					pass_ethmac <= 1'b0;
				if (want_ip && !cfg_hit)
					pass_dst_ip <= 1'b0;
				if (want_arp && !cfg_hit)
					pass_arp_ip <= 1'b0;
			end
		end
	end

	// Memory answer matches data_d1 only while pos steps by one
	assert property (@(posedge clk) disable iff (!rst_n)
		(want_eth || want_ip || want_arp) && pos != '0 |-> pos == $past(pos) + 11'd1)
		else $error("position skipped inside a config compare window");

endmodule

`default_nettype wire

// ==== logic/ip_check.sv ====
// IPv4 header checker with template, TTL, header checksum and total length capture
`timescale 1ns/1ps
`default_nettype none

module ip_check
	import scan_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire pos_t   pos,
	input  wire octet_s data_d1,
	output logic        ip_ok,
	output logic [15:0] ip_length
);

	logic [7:0] tmpl;
	logic [7:0] df_mask;
	logic [7:0] len_hi;
	logic want, mask_df, ttl_flag;
	logic pass_r, chksum_fail;
	logic sum_gate, sum_clear, sum_ones;
	logic hdr_match, zero_ttl;

	// Expected octets, checked one cycle later
	always_ff @(posedge clk) begin
		case (pos)
			// Ethertype IPv4
			11'd12:  tmpl <= 8'h08;
			11'd13:  tmpl <= 8'h00;
			// Version 4, five-word header
			11'd14:  tmpl <= 8'h45;
			// Flags and fragment offset
			11'd20:  tmpl <= 8'h00;
			11'd21:  tmpl <= 8'h00;
			default: tmpl <= 8'h00;
		endcase
	end

	// DF is the only flag allowed
	assign df_mask   = {1'b1, ~mask_df, 6'h3f};
	assign hdr_match = (data_d1.data & df_mask) == tmpl;
	assign zero_ttl  = ttl_flag && data_d1.data == 8'h00;
	assign sum_clear = pos == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want        <= 1'b0;
			mask_df     <= 1'b0;
			ttl_flag    <= 1'b0;
			sum_gate    <= 1'b0;
			pass_r      <= 1'b0;
			chksum_fail <= 1'b0;
			len_hi      <= 8'h00;
			ip_length   <= 16'h0000;
		end else begin
			want     <= (pos >= 11'd12 && pos < 11'd15) || pos == 11'd20 || pos == 11'd21;
			mask_df  <= pos == 11'd20;
			ttl_flag <= pos == 11'd22;
			// Header octets 14 to 33
			sum_gate <= pos >= 11'd14 && pos < 11'd34;
			if (pos == '0) begin
				pass_r      <= 1'b1;
				chksum_fail <= 1'b0;
			end else begin
				if ((want && !hdr_match) || zero_ttl)
					pass_r <= 1'b0;
				// Last header octet summed by now
				if (pos == 11'd35)
					chksum_fail <= ~sum_ones;
			end
			// Total length, octets 16 and 17
			if (pos == 11'd17)
				len_hi <= data_d1.data;
			if (pos == 11'd18)
				ip_length <= {len_hi, data_d1.data};
		end
	end

	ones_chksum i_hdr_sum (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (sum_clear),
		.gate     (sum_gate),
		.din      (data_d1.data),
		.all_ones (sum_ones)
	);

	assign ip_ok = pass_r & ~chksum_fail;

endmodule

`default_nettype wire

// ==== logic/proto_match.sv ====
// Protocol matcher for ARP request, ICMP echo with checksum and UDP port/length rules
`timescale 1ns/1ps
`default_nettype none

module proto_match
	import scan_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire pos_t   pos,
	input  wire octet_s data_d1,
	input  wire  [15:0] ip_length,
	output logic        arp_ok,
	output logic        icmp_ok,
	output logic        udp_ok,
	output logic        unicast_src
);

	logic [7:0]  tmpl;
	logic [7:0]  proto;
	logic [7:0]  ulen_hi;
	logic [15:0] udp_len;
	logic [16:0] pos_w, ip_end;
	logic want_arp, want_icmp, arp_pass, icmp_pass;
	logic sum_gate, sum_clear, sum_ones, sum_ok;
	logic sport_ok, dport_hi_nz, dport_ok;
	logic tmpl_hit;

	// ARP header from the ethertype on, then ICMP type and code
	always_ff @(posedge clk) begin
		case (pos)
			11'd12:  tmpl <= 8'h08;
			11'd13:  tmpl <= 8'h06;
			11'd14:  tmpl <= 8'h00;
			11'd15:  tmpl <= 8'h01;
			11'd16:  tmpl <= 8'h08;
			11'd17:  tmpl <= 8'h00;
			11'd18:  tmpl <= 8'h06;
			11'd19:  tmpl <= 8'h04;
			11'd20:  tmpl <= 8'h00;
			// Request opcode
			11'd21:  tmpl <= 8'h01;
			// Echo request, code 0
			11'd34:  tmpl <= 8'h08;
			default: tmpl <= 8'h00;
		endcase
	end

	assign tmpl_hit  = data_d1.data == tmpl;
	assign pos_w     = {6'd0, pos};
	// First position past the IP datagram
	assign ip_end    = {1'b0, ip_length} + 17'd14;
	assign sum_clear = pos == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			want_arp    <= 1'b0;
			want_icmp   <= 1'b0;
			sum_gate    <= 1'b0;
			arp_pass    <= 1'b0;
			icmp_pass   <= 1'b0;
			sum_ok      <= 1'b0;
			unicast_src <= 1'b0;
			proto       <= 8'h00;
			sport_ok    <= 1'b0;
			dport_hi_nz <= 1'b0;
			dport_ok    <= 1'b0;
			ulen_hi     <= 8'h00;
			udp_len     <= 16'h0000;
		end else begin
			want_arp  <= pos >= 11'd12 && pos < 11'd22;
			want_icmp <= pos == 11'd34 || pos == 11'd35;
			// ICMP message to the end of the datagram
			sum_gate  <= pos >= 11'd34 && pos_w < ip_end;
			if (pos == '0) begin
				arp_pass    <= 1'b1;
				icmp_pass   <= 1'b1;
				sum_ok      <= 1'b0;
				unicast_src <= 1'b1;
				proto       <= 8'h00;
				sport_ok    <= 1'b0;
				dport_ok    <= 1'b0;
			end else begin
				if (want_arp && !tmpl_hit)
					arp_pass <= 1'b0;
				if (want_icmp && !tmpl_hit)
					icmp_pass <= 1'b0;
				if (pos > 11'd34 && pos_w == ip_end + 17'd1)
					sum_ok <= sum_ones;
				// Group bit of the source MAC
				if (pos == 11'd7)
					unicast_src <= ~data_d1.data[0];
				if (pos == 11'd24)
					proto <= data_d1.data;
				// Source port 1024 and up
				if (pos == 11'd35)
					sport_ok <= |data_d1.data[7:2];
				if (pos == 11'd37)
					dport_hi_nz <= |data_d1.data;
				if (pos == 11'd38)
					dport_ok <= dport_hi_nz | (|data_d1.data);
				if (pos == 11'd39)
					ulen_hi <= data_d1.data;
				if (pos == 11'd40)
					udp_len <= {ulen_hi, data_d1.data};
			end
		end
	end

	ones_chksum i_icmp_sum (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (sum_clear),
		.gate     (sum_gate),
		.din      (data_d1.data),
		.all_ones (sum_ones)
	);

	assign arp_ok  = arp_pass;
	assign icmp_ok = icmp_pass & sum_ok & (proto == 8'h01);
	// UDP datagram has to fit behind a 20-octet IP header
	assign udp_ok  = (proto == 8'h11) & sport_ok & dport_ok &
		({1'b0, ip_length} >= {1'b0, udp_len} + 17'd20);

endmodule

`default_nettype wire

// ==== logic/pkt_scanner.sv ====
// Packet scanner top with frame FSM, checkers and the end-of-frame status word
`timescale 1ns/1ps
`default_nettype none

module pkt_scanner
	import scan_pkg::*;
#(
	parameter int cfg_aw = 4
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire  [7:0]        eth_in,
	input  wire               eth_in_s,
	input  wire               enable_rx,
	output logic [cfg_aw-1:0] cfg_addr,
	input  wire  [7:0]        cfg_data,
	output octet_s            odata,
	output logic              odata_s,
	output logic              odata_f,
	output logic              status_valid,
	output scan_status_s      status
);

	pos_t pos, frame_len;
	octet_s data_d1;
	logic in_frame, frame_end;
	logic pass_ethmac, pass_dst_ip, pass_arp_ip;
	logic ip_ok, arp_ok, icmp_ok, udp_ok, unicast_src;
	logic [15:0] ip_length;
	logic len_ok;
	logic pass_ip, pass_arp, pass_icmp, pass_udp;
	scan_status_s status_now, status_r;

	frame_fsm i_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.eth_in    (eth_in),
		.eth_in_s  (eth_in_s),
		.enable_rx (enable_rx),
		.pos       (pos),
		.in_frame  (in_frame),
		.data_d1   (data_d1),
		.odata     (odata),
		.odata_s   (odata_s),
		.frame_end (frame_end),
		.frame_len (frame_len)
	);

	addr_match #(.cfg_aw(cfg_aw)) i_addr (
		.clk         (clk),
		.rst_n       (rst_n),
		.pos         (pos),
		.data_d1     (data_d1),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.pass_ethmac (pass_ethmac),
		.pass_dst_ip (pass_dst_ip),
		.pass_arp_ip (pass_arp_ip)
	);

	ip_check i_ip (
		.clk       (clk),
		.rst_n     (rst_n),
		.pos       (pos),
		.data_d1   (data_d1),
		.ip_ok     (ip_ok),
		.ip_length (ip_length)
	);

	proto_match i_proto (
		.clk         (clk),
		.rst_n       (rst_n),
		.pos         (pos),
		.data_d1     (data_d1),
		.ip_length   (ip_length),
		.arp_ok      (arp_ok),
		.icmp_ok     (icmp_ok),
		.udp_ok      (udp_ok),
		.unicast_src (unicast_src)
	);

	// Octet count covers the datagram, the Ethernet header and the FCS
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			len_ok <= 1'b0;
		else if (in_frame)
			len_ok <= {6'd0, pos} >= {1'b0, ip_length} + 17'd18;
	end

	assign pass_ip   = pass_ethmac & unicast_src & ip_ok & pass_dst_ip & len_ok;
	assign pass_udp  = pass_ip & udp_ok;
	assign pass_icmp = pass_ip & icmp_ok;
	// Broadcast ARP is fine, so no destination MAC here
	assign pass_arp  = unicast_src & arp_ok & pass_arp_ip;

	always_comb begin
		status_now.category    = pass_udp  ? cat_udp  :
		                         pass_icmp ? cat_icmp :
		                         pass_arp  ? cat_arp  : cat_other;
		status_now.pass_ethmac = pass_ethmac;
		status_now.pass_ip     = pass_ip;
		status_now.frame_len   = frame_len;
	end

	// Checker flags restart with the next frame, keep a copy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			status_r <= '0;
		else if (frame_end)
			status_r <= status_now;
	end

	assign status       = frame_end ? status_now : status_r;
	assign status_valid = frame_end;
	assign odata_f      = frame_end;

	// One status per frame, frames are never back to back
	assert property (@(posedge clk) disable iff (!rst_n)
		status_valid |=> !status_valid)
		else $error("status_valid on adjacent cycles");

endmodule

`default_nettype wire

// ==== tests/tb_scanner.sv ====
// Testbench for the packet scanner, drives a table of frames and checks stream and status
`timescale 1ns/1ps
`default_nettype none

module tb_scanner
	import scan_pkg::*;
;

	localparam int cfg_aw = 4;
	// Frame kinds
	localparam logic [1:0] k_udp = 2'd0, k_icmp = 2'd1, k_arp = 2'd2;
	// Injected faults
	localparam logic [3:0] f_none = 4'd0, f_icmp_flip = 4'd1, f_arp_tip = 4'd2;
	localparam logic [3:0] f_hdr_cks = 4'd3, f_ttl0 = 4'd4, f_frag = 4'd5, f_dst_mac = 4'd6;
	localparam logic [3:0] f_sport53 = 4'd7, f_preamble = 4'd8, f_short_gap = 4'd9;
	localparam logic [3:0] f_rx_off = 4'd10;
	localparam int n_frames = 16;

	typedef struct packed {
		logic [1:0] kind;
		logic [3:0] fault;
		logic [7:0] plen;
		category_e  cat;
		logic       eth;
		logic       ip;
		// Frame should reach the output at all
		logic       accept;
	} desc_s;

	logic clk = 1'b0;
	logic rst_n;
	logic [7:0] eth_in;
	logic eth_in_s, enable_rx;
	logic [cfg_aw-1:0] cfg_addr;
	logic [7:0] cfg_data = 8'h00;
	octet_s odata;
	logic odata_s, odata_f, status_valid;
	scan_status_s status;

	logic [7:0] cfg_mem [0:(1<<cfg_aw)-1];
	logic [7:0] frame_buf [0:1535];
	int frame_n;
	desc_s desc_tab [0:n_frames-1];
	// Octets driven one and two cycles back
	octet_s hist1, hist2;
	int beats, status_hits, flag_hits, err_value, err_other;
	scan_status_s got_status, exp_hold;
	// Status of the last accepted frame is known
	logic hold_valid;

	pkt_scanner #(.cfg_aw(cfg_aw)) i_dut (
		.clk(clk), .rst_n(rst_n), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.enable_rx(enable_rx), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.odata(odata), .odata_s(odata_s), .odata_f(odata_f),
		.status_valid(status_valid), .status(status)
	);

	always #4 clk = ~clk;

	// Config memory answers one cycle after the address
	always @(posedge clk)
		cfg_data <= cfg_mem[cfg_addr];

	function automatic desc_s make_desc(input logic [1:0] kind, input logic [3:0] fault,
		input logic [7:0] plen, input category_e cat, input logic eth, input logic ip,
		input logic accept);
		desc_s d;
		d.kind = kind;
		d.fault = fault;
		d.plen = plen;
		d.cat = cat;
		d.eth = eth;
		d.ip = ip;
		d.accept = accept;
		return d;
	endfunction

	// Folded 16-bit one's-complement sum over frame_buf[first..last-1]
	function automatic logic [15:0] ones_sum(input int first, input int last);
		logic [31:0] s;
		int i;
		s = 0;
		for (i = first; i < last; i += 2)
			s += {frame_buf[i], (i + 1 < last) ? frame_buf[i+1] : 8'h00};
		while (s[31:16] != 0)
			s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
		return s[15:0];
	endfunction

	function automatic string status_text(input scan_status_s s);
		return $sformatf("cat %0d eth %b ip %b len %0d", s.category, s.pass_ethmac,
			s.pass_ip, s.frame_len);
	endfunction

	task automatic check_status(input scan_status_s got, input scan_status_s exp);
		if (got !== exp) begin
			$display("FAIL at time %0t: status expected %s, got %s",
				$time, status_text(exp), status_text(got));
			err_value++;
		end
	endtask

	task automatic check_octet(input octet_s got, input octet_s exp);
		if (got !== exp) begin
			$display("FAIL at time %0t: odata expected %h, got %h", $time, exp, got);
			err_value++;
		end
	endtask

	// Sample the outputs, then drive new inputs on the falling edge
	task automatic drive_cycle(input logic [7:0] d, input logic s, input logic f);
		@(negedge clk);
		if (odata_s) begin
			beats++;
			check_octet(odata, hist2);
		end
		if (odata_f)
			flag_hits++;
		if (status_valid) begin
			status_hits++;
			got_status = status;
		end else if (hold_valid) begin
			check_status(status, exp_hold);
		end
		eth_in = d;
		eth_in_s = s;
		hist2 = hist1;
		hist1.data = s ? d : 8'h00;
		hist1.first = f;
	endtask

	task automatic build_frame(input desc_s d);
		int i, ulen, iplen, p;
		logic [15:0] cks;
		for (i = 0; i < 6; i++)
			frame_buf[i] = (d.kind == k_arp) ? 8'hff : cfg_mem[i];
		if (d.fault == f_dst_mac)
			frame_buf[5] ^= 8'h01;
		{frame_buf[6], frame_buf[7], frame_buf[8]} = 24'h02aabb;
		{frame_buf[9], frame_buf[10], frame_buf[11]} = 24'hccddee;
		if (d.kind == k_arp) begin
			{frame_buf[12], frame_buf[13], frame_buf[14], frame_buf[15]} = 32'h08060001;
			{frame_buf[16], frame_buf[17], frame_buf[18], frame_buf[19]} = 32'h08000604;
			{frame_buf[20], frame_buf[21]} = 16'h0001;
			for (i = 0; i < 6; i++) begin
				frame_buf[22+i] = frame_buf[6+i];
				frame_buf[32+i] = 8'h00;
			end
			{frame_buf[28], frame_buf[29], frame_buf[30], frame_buf[31]} = 32'h0a000007;
			for (i = 0; i < 4; i++)
				frame_buf[38+i] = cfg_mem[6+i];
			if (d.fault == f_arp_tip)
				frame_buf[41] ^= 8'h01;
			for (p = 42; p < 60; p++)
				frame_buf[p] = 8'h00;
		end else begin
			ulen = 8 + d.plen;
			iplen = 20 + ulen;
			{frame_buf[12], frame_buf[13], frame_buf[14], frame_buf[15]} = 32'h08004500;
			{frame_buf[16], frame_buf[17]} = iplen[15:0];
			{frame_buf[18], frame_buf[19], frame_buf[20]} = 24'h123440;
			frame_buf[21] = (d.fault == f_frag) ? 8'h05 : 8'h00;
			frame_buf[22] = (d.fault == f_ttl0) ? 8'h00 : 8'h40;
			frame_buf[23] = (d.kind == k_udp) ? 8'h11 : 8'h01;
			{frame_buf[24], frame_buf[25]} = 16'h0000;
			{frame_buf[26], frame_buf[27], frame_buf[28], frame_buf[29]} = 32'h0a000007;
			for (i = 0; i < 4; i++)
				frame_buf[30+i] = cfg_mem[6+i];
			cks = ~ones_sum(14, 34);
			if (d.fault == f_hdr_cks)
				cks ^= 16'h0101;
			{frame_buf[24], frame_buf[25]} = cks;
			if (d.kind == k_udp) begin
				{frame_buf[34], frame_buf[35]} = (d.fault == f_sport53) ? 16'd53 : 16'd5000;
				{frame_buf[36], frame_buf[37]} = 16'd4000;
				{frame_buf[38], frame_buf[39]} = ulen[15:0];
				{frame_buf[40], frame_buf[41]} = 16'h0000;
			end else begin
				{frame_buf[34], frame_buf[35], frame_buf[36], frame_buf[37]} = 32'h08000000;
				{frame_buf[38], frame_buf[39], frame_buf[40], frame_buf[41]} = 32'h00010007;
			end
			for (i = 0; i < d.plen; i++)
				frame_buf[42+i] = 8'($urandom);
			if (d.kind == k_icmp) begin
				{frame_buf[36], frame_buf[37]} = ~ones_sum(34, 34 + ulen);
				if (d.fault == f_icmp_flip)
					frame_buf[42] ^= 8'h20;
			end
			p = 34 + ulen;
		end
		// FCS is carried but never checked
		for (i = 0; i < 4; i++)
			frame_buf[p+i] = 8'($urandom);
		frame_n = p + 4;
	endtask

	task automatic send_frame(input desc_s d);
		int i, n_pre, wait_cnt;
		scan_status_s exp;
		beats = 0;
		status_hits = 0;
		flag_hits = 0;
		build_frame(d);
		if (d.fault == f_rx_off)
			enable_rx = 1'b0;
		if (d.fault != f_short_gap)
			repeat (12) drive_cycle(8'h00, 1'b0, 1'b0);
		n_pre = (d.fault == f_short_gap) ? 1 : 7;
		for (i = 0; i < n_pre; i++)
			drive_cycle((d.fault == f_preamble && i == 3) ? 8'h5d : 8'h55, 1'b1, 1'b0);
		drive_cycle(8'hd5, 1'b1, 1'b0);
		for (i = 0; i < frame_n; i++)
			drive_cycle(frame_buf[i], 1'b1, i == 0);
		if (d.accept) begin
			wait_cnt = 0;
			while (status_hits == 0 && wait_cnt < 16) begin
				drive_cycle(8'h00, 1'b0, 1'b0);
				wait_cnt++;
			end
			if (status_hits == 0) begin
				$display("Timeout: no status after frame with fault %0d", d.fault);
				err_other++;
			end else begin
				exp.category = d.cat;
				exp.pass_ethmac = d.eth;
				exp.pass_ip = d.ip;
				exp.frame_len = pos_t'(frame_n - 1);
				check_status(got_status, exp);
				exp_hold = exp;
				hold_valid = 1'b1;
				// Status is due in the cycle after the first low strobe
				if (wait_cnt != 2) begin
					$display("Status came %0d cycles after the frame ended, one expected",
						wait_cnt - 1);
					err_other++;
				end
			end
			if (flag_hits != 1) begin
				$display("odata_f pulsed %0d times at the end of a frame, once expected",
					flag_hits);
				err_other++;
			end
			if (beats != frame_n) begin
				$display("Output carried %0d octets, the frame had %0d", beats, frame_n);
				err_other++;
			end
		end else begin
			repeat (16) drive_cycle(8'h00, 1'b0, 1'b0);
			if (beats != 0 || status_hits != 0 || flag_hits != 0) begin
				$display("Rejected frame with fault %0d still reached the output", d.fault);
				err_other++;
			end
		end
		enable_rx = 1'b1;
	endtask

	initial begin
		int i;
		void'($urandom(19649));
		err_value = 0;
		err_other = 0;
		rst_n = 1'b0;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		enable_rx = 1'b1;
		hist1 = '0;
		hist2 = '0;
		exp_hold = '0;
		hold_valid = 1'b0;
		// Our MAC, our IPv4 address, then filler
		{cfg_mem[0], cfg_mem[1], cfg_mem[2]} = 24'h021122;
		{cfg_mem[3], cfg_mem[4], cfg_mem[5]} = 24'h334455;
		{cfg_mem[6], cfg_mem[7], cfg_mem[8], cfg_mem[9]} = 32'hc0a80114;
		for (i = 10; i < (1 << cfg_aw); i++)
			cfg_mem[i] = 8'(i * 37 + 5);
		desc_tab[0]  = make_desc(k_udp,  f_none,      8'd18, cat_udp,   1, 1, 1);
		desc_tab[1]  = make_desc(k_icmp, f_none,      8'd16, cat_icmp,  1, 1, 1);
		desc_tab[2]  = make_desc(k_icmp, f_icmp_flip, 8'd16, cat_other, 1, 1, 1);
		desc_tab[3]  = make_desc(k_arp,  f_none,      8'd0,  cat_arp,   0, 0, 1);
		desc_tab[4]  = make_desc(k_arp,  f_arp_tip,   8'd0,  cat_other, 0, 0, 1);
		desc_tab[5]  = make_desc(k_udp,  f_hdr_cks,   8'd18, cat_other, 1, 0, 1);
		desc_tab[6]  = make_desc(k_udp,  f_ttl0,      8'd18, cat_other, 1, 0, 1);
		desc_tab[7]  = make_desc(k_udp,  f_frag,      8'd18, cat_other, 1, 0, 1);
		desc_tab[8]  = make_desc(k_udp,  f_dst_mac,   8'd18, cat_other, 0, 0, 1);
		desc_tab[9]  = make_desc(k_udp,  f_sport53,   8'd18, cat_other, 1, 1, 1);
		desc_tab[10] = make_desc(k_udp,  f_preamble,  8'd18, cat_other, 0, 0, 0);
		desc_tab[11] = make_desc(k_udp,  f_none,      8'd30, cat_udp,   1, 1, 1);
		desc_tab[12] = make_desc(k_udp,  f_short_gap, 8'd18, cat_other, 0, 0, 0);
		desc_tab[13] = make_desc(k_icmp, f_none,      8'd20, cat_icmp,  1, 1, 1);
		desc_tab[14] = make_desc(k_udp,  f_rx_off,    8'd18, cat_other, 0, 0, 0);
		desc_tab[15] = make_desc(k_udp,  f_none,      8'd18, cat_udp,   1, 1, 1);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (i = 0; i < n_frames; i++)
			send_frame(desc_tab[i]);
		repeat (4) drive_cycle(8'h00, 1'b0, 1'b0);
		$display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
logic/scan_pkg.sv
logic/frame_fsm.sv
logic/ones_chksum.sv
logic/addr_match.sv
logic/ip_check.sv
logic/proto_match.sv
logic/pkt_scanner.sv
tests/tb_scanner.sv
